// ==== logic/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and address width
`define CPU_XLEN 32

`define CPU_NREGS 32
`define CPU_RADDR_W 5

// jal writes its return address here
`define CPU_LINK_REG 31

`define CPU_RESET_PC 32'h0000_0000
`define CPU_PC_STEP 32'd4

`endif

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

`include "cpu_consts.svh"

    typedef enum logic [4:0] {
        st_if  = 5'b00001,
        st_id  = 5'b00010,
        st_exe = 5'b00100,
        st_mem = 5'b01000,
        st_wb  = 5'b10000
    } cpu_state_e;

    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_j       = 6'b000010,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_addiu   = 6'b001001,
        op_slti    = 6'b001010,
        op_sltiu   = 6'b001011,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        fn_jr   = 6'b001000,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_nor  = 6'b100111,
        fn_slt  = 6'b101010,
        fn_sltu = 6'b101011
    } funct_e;

    typedef enum logic [2:0] {
        alu_and  = 3'b000,
        alu_or   = 3'b001,
        alu_add  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_nor  = 3'b101,
        alu_sub  = 3'b110,
        alu_slt  = 3'b111
    } alu_op_e;

    typedef enum logic [2:0] {
        cls_nop,
        cls_alu,
        cls_branch,
        cls_jump,
        cls_load,
        cls_store
    } instr_class_e;

    typedef struct packed {
        instr_class_e              cls;
        alu_op_e                   alu_op;
        logic                      use_imm;
        logic                      zero_ext;
        logic                      is_lui;
        logic                      is_bne;
        logic                      link;
        logic                      jreg;
        logic [`CPU_RADDR_W-1:0]   rd;
        logic [15:0]               imm;
        logic [25:0]               jidx;
    } decode_ctrl_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] rs_val;
        logic [`CPU_XLEN-1:0] rt_val;
    } operands_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]    value;      // ALU result, lui value, link or address
        logic [`CPU_XLEN-1:0]    store_data;
        logic [`CPU_RADDR_W-1:0] rd;
        logic                    wen;
        logic                    load;
        logic                    store;
    } exec_result_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
    } imem_port_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
        logic                 write;
        logic                 read;
    } dmem_req_t;

endpackage

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

`include "cpu_consts.svh"

module reg_file import cpu_pkg::*; (
    input  logic                    clk,
    input  logic [`CPU_RADDR_W-1:0] raddr1,
    input  logic [`CPU_RADDR_W-1:0] raddr2,
    output operands_t               rdata,
    input  logic                    wen,
    input  logic [`CPU_RADDR_W-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]    wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Register 0 is never written, so force its read value
    assign rdata.rs_val = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata.rt_val = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  alu_op_e              op,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 zero
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_slt:  result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            default:  result = a + b;
        endcase
    end

    assign zero = (result == '0);   // Branch compare on a subtraction

endmodule

// ==== logic/cpu_fsm.sv ====
`timescale 1ns/1ps

module cpu_fsm import cpu_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  decode_ctrl_t ctrl,
    output cpu_state_e   state
);

    cpu_state_e   next_state;
    instr_class_e cls_q;
    logic         link_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_if;
            cls_q  <= cls_nop;
            link_q <= 1'b0;
        end else begin
            state <= next_state;
            if (state == st_id) begin
                cls_q  <= ctrl.cls;
                link_q <= ctrl.link;
            end
        end
    end

    always_comb begin
        case (state)
            st_if:  next_state = st_id;
            st_id:  next_state = (ctrl.cls == cls_nop) ? st_if : st_exe;
            st_exe: begin
                case (cls_q)
                    cls_alu:              next_state = st_wb;
                    cls_jump:             next_state = link_q ? st_wb : st_if;
                    cls_load, cls_store:  next_state = st_mem;
                    default:              next_state = st_if;   // Branches end here
                endcase
            end
            st_mem: next_state = (cls_q == cls_load) ? st_wb : st_if;
            default: next_state = st_if;
        endcase
    end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

`include "cpu_consts.svh"

module fetch_unit import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_state_e           state,
    input  logic [`CPU_XLEN-1:0] instruction,
    input  logic                 redirect,
    input  logic [`CPU_XLEN-1:0] target,
    output imem_port_t           imem,
    output logic [`CPU_XLEN-1:0] instr,
    output logic [`CPU_XLEN-1:0] pc_plus
);

    logic [`CPU_XLEN-1:0] pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CPU_RESET_PC;
        end else if (state == st_if) begin
            pc <= pc + `CPU_PC_STEP;
        end else if (state == st_exe && redirect) begin
            pc <= target;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_if) begin
            instr <= instruction;
        end
    end

    assign imem.pc = pc;
    assign pc_plus = pc;   // Already stepped once fetch is done

endmodule

// ==== logic/decoder.sv ====
`timescale 1ns/1ps

`include "cpu_consts.svh"

module decoder import cpu_pkg::*; (
    input  logic [`CPU_XLEN-1:0]    instr,
    output logic [`CPU_RADDR_W-1:0] raddr1,
    output logic [`CPU_RADDR_W-1:0] raddr2,
    output decode_ctrl_t            ctrl
);

    opcode_e                 opcode;
    funct_e                  funct;
    logic [`CPU_RADDR_W-1:0] rt;
    logic [`CPU_RADDR_W-1:0] rd;
    alu_op_e                 r_op;
    alu_op_e                 i_op;
    logic                    r_valid;
    logic                    is_jr;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign raddr1 = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign raddr2 = rt;
    assign is_jr  = (funct == fn_jr);

    always_comb begin
        r_valid = 1'b1;
        case (funct)
            fn_addu: r_op = alu_add;
            fn_subu: r_op = alu_sub;
            fn_and:  r_op = alu_and;
            fn_or:   r_op = alu_or;
            fn_xor:  r_op = alu_xor;
            fn_nor:  r_op = alu_nor;
            fn_slt:  r_op = alu_slt;
            fn_sltu: r_op = alu_sltu;
            default: begin
                r_op    = alu_add;
                r_valid = 1'b0;   // jr and the all-zero word land here
            end
        endcase
    end

    always_comb begin
        case (opcode)
            op_slti:        i_op = alu_slt;
            op_sltiu:       i_op = alu_sltu;
            op_andi:        i_op = alu_and;
            op_ori:         i_op = alu_or;
            op_xori:        i_op = alu_xor;
            op_beq, op_bne: i_op = alu_sub;
            default:        i_op = alu_add;   // addiu, lw and sw address
        endcase
    end

    always_comb begin
        ctrl.cls      = cls_nop;
        ctrl.alu_op   = i_op;
        ctrl.use_imm  = 1'b0;
        ctrl.zero_ext = (opcode == op_andi) || (opcode == op_ori) || (opcode == op_xori);
        ctrl.is_lui   = (opcode == op_lui);
        ctrl.is_bne   = (opcode == op_bne);
        ctrl.link     = (opcode == op_jal);
        ctrl.jreg     = 1'b0;
        ctrl.rd       = rt;
        ctrl.imm      = instr[15:0];
        ctrl.jidx     = instr[25:0];
        case (opcode)
            op_special: begin
                ctrl.alu_op = r_op;
                ctrl.rd     = rd;
                ctrl.jreg   = is_jr;
                if (r_valid) begin
                    ctrl.cls = cls_alu;
                end else if (is_jr) begin
                    ctrl.cls = cls_jump;
                end
            end
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                ctrl.cls     = cls_alu;
                ctrl.use_imm = 1'b1;
            end
            op_beq, op_bne: ctrl.cls = cls_branch;
            op_j:           ctrl.cls = cls_jump;
            op_jal: begin
                ctrl.cls = cls_jump;
                ctrl.rd  = `CPU_RADDR_W'(`CPU_LINK_REG);
            end
            op_lw: begin
                ctrl.cls     = cls_load;
                ctrl.use_imm = 1'b1;
            end
            op_sw: begin
                ctrl.cls     = cls_store;
                ctrl.use_imm = 1'b1;
            end
            default: ctrl.cls = cls_nop;
        endcase
    end

endmodule

// ==== logic/exec_stage.sv ====
`timescale 1ns/1ps

`include "cpu_consts.svh"

module exec_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  cpu_state_e           state,
    input  decode_ctrl_t         ctrl,
    input  operands_t            ops,
    input  logic [`CPU_XLEN-1:0] pc_plus,
    output logic                 redirect,
    output logic [`CPU_XLEN-1:0] target,
    output exec_result_t         result
);

    decode_ctrl_t         ctrl_q;
    operands_t            ops_q;
    logic [`CPU_XLEN-1:0] imm_ext;
    logic [`CPU_XLEN-1:0] alu_b;
    logic [`CPU_XLEN-1:0] alu_res;
    logic [`CPU_XLEN-1:0] lui_val;
    logic [`CPU_XLEN-1:0] br_target;
    logic [`CPU_XLEN-1:0] jump_target;
    logic                 alu_zero;
    logic                 taken;

    always_ff @(posedge clk) begin
        if (state == st_id) begin
            ctrl_q <= ctrl;
            ops_q  <= ops;
        end
    end

    assign imm_ext = ctrl_q.zero_ext ? {{(`CPU_XLEN-16){1'b0}}, ctrl_q.imm}
                                     : {{(`CPU_XLEN-16){ctrl_q.imm[15]}}, ctrl_q.imm};
    assign alu_b   = ctrl_q.use_imm ? imm_ext : ops_q.rt_val;
    assign lui_val = {ctrl_q.imm, {(`CPU_XLEN-16){1'b0}}};

    alu u_alu (
        .a      (ops_q.rs_val),
        .b      (alu_b),
        .op     (ctrl_q.alu_op),
        .result (alu_res),
        .zero   (alu_zero)
    );

    assign taken       = (ctrl_q.cls == cls_branch) && (alu_zero != ctrl_q.is_bne);
    assign br_target   = pc_plus + {imm_ext[`CPU_XLEN-3:0], 2'b00};
    assign jump_target = {pc_plus[`CPU_XLEN-1:28], ctrl_q.jidx, 2'b00};

    assign redirect = (state == st_exe) && (taken || ctrl_q.cls == cls_jump);
    assign target   = ctrl_q.jreg ? ops_q.rs_val :
                      (ctrl_q.cls == cls_jump) ? jump_target : br_target;

    always_ff @(posedge clk) begin
        if (state == st_exe) begin
            result.value      <= ctrl_q.link ? pc_plus : (ctrl_q.is_lui ? lui_val : alu_res);
            result.store_data <= ops_q.rt_val;
            result.rd         <= ctrl_q.rd;
            result.wen        <= (ctrl_q.cls == cls_alu) || (ctrl_q.cls == cls_load) ||
                                 ctrl_q.link;
            result.load       <= (ctrl_q.cls == cls_load);
            result.store      <= (ctrl_q.cls == cls_store);
        end
    end

endmodule

// ==== logic/mem_wb_stage.sv ====
`timescale 1ns/1ps

`include "cpu_consts.svh"

module mem_wb_stage import cpu_pkg::*; (
    input  logic                    clk,
    input  cpu_state_e              state,
    input  exec_result_t            result,
    output dmem_req_t               dmem,
    input  logic [`CPU_XLEN-1:0]    read_data,
    output logic                    wen,
    output logic [`CPU_RADDR_W-1:0] waddr,
    output logic [`CPU_XLEN-1:0]    wdata
);

    logic [`CPU_XLEN-1:0] load_q;

    // Only full words are moved, so the low address bits are dropped
    assign dmem.addr  = {result.value[`CPU_XLEN-1:2], 2'b00};
    assign dmem.wdata = result.store_data;
    assign dmem.write = (state == st_mem) && result.store;
    assign dmem.read  = (state == st_mem) && result.load;

    always_ff @(posedge clk) begin
        if (dmem.read) begin
            load_q <= read_data;   // Memory answers in the same cycle
        end
    end

    assign wen   = (state == st_wb) && result.wen;
    assign waddr = result.rd;
    assign wdata = result.load ? load_q : result.value;

endmodule

// ==== logic/simple_cpu.sv ====
`timescale 1ns/1ps

`include "cpu_consts.svh"

module simple_cpu import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    output imem_port_t           imem,
    input  logic [`CPU_XLEN-1:0] instruction,
    output dmem_req_t            dmem,
    input  logic [`CPU_XLEN-1:0] read_data
);

    cpu_state_e              state;
    decode_ctrl_t            ctrl;
    operands_t               ops;
    exec_result_t            ex_result;
    logic [`CPU_XLEN-1:0]    instr;
    logic [`CPU_XLEN-1:0]    pc_plus;
    logic [`CPU_XLEN-1:0]    target;
    logic                    redirect;
    logic [`CPU_RADDR_W-1:0] raddr1;
    logic [`CPU_RADDR_W-1:0] raddr2;
    logic                    rf_wen;
    logic [`CPU_RADDR_W-1:0] rf_waddr;
    logic [`CPU_XLEN-1:0]    rf_wdata;

    cpu_fsm u_fsm (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (ctrl),
        .state (state)
    );

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .instruction (instruction),
        .redirect    (redirect),
        .target      (target),
        .imem        (imem),
        .instr       (instr),
        .pc_plus     (pc_plus)
    );

    decoder u_dec (
        .instr  (instr),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .ctrl   (ctrl)
    );

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata  (ops),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    exec_stage u_exec (
        .clk      (clk),
        .state    (state),
        .ctrl     (ctrl),
        .ops      (ops),
        .pc_plus  (pc_plus),
        .redirect (redirect),
        .target   (target),
        .result   (ex_result)
    );

    mem_wb_stage u_mem_wb (
        .clk       (clk),
        .state     (state),
        .result    (ex_result),
        .dmem      (dmem),
        .read_data (read_data),
        .wen       (rf_wen),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata)
    );

endmodule

// ==== sim/tb_simple_cpu.sv ====
`timescale 1ns/1ps

`include "cpu_consts.svh"

module tb_simple_cpu import cpu_pkg::*; ;

    logic                 clk;
    logic                 rst;
    imem_port_t           imem;
    logic [`CPU_XLEN-1:0] instruction;
    dmem_req_t            dmem;
    logic [`CPU_XLEN-1:0] read_data;

    logic [31:0] prog     [256];
    logic [31:0] data_mem [256];
    logic [31:0] ref_mem  [256];
    logic [31:0] ref_regs [32];
    int          n_writes = 0;
    int          pc_w;
    logic [15:0] st_off;
    logic [31:0] loop_pc;

    simple_cpu dut0 (
        .clk         (clk),
        .rst         (rst),
        .imem        (imem),
        .instruction (instruction),
        .dmem        (dmem),
        .read_data   (read_data)
    );

    // Both memories answer within the same cycle
    assign instruction = prog[imem.pc[9:2]];
    assign read_data   = data_mem[dmem.addr[9:2]];

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (dmem.write === 1'b1) begin
            data_mem[dmem.addr[9:2]] <= dmem.wdata;
        end
    end

    always @(negedge clk) begin
        if (dmem.write === 1'b1) begin
            n_writes++;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure("a DUT output differs from the reference model");
        end
    endtask

    task automatic check_idle();
        compare("dmem.write", {31'b0, dmem.write}, 32'b0);
        compare("dmem.read", {31'b0, dmem.read}, 32'b0);
        compare("imem.pc", imem.pc, `CPU_RESET_PC);
    endtask

    function automatic logic [31:0] r_ins(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] i_ins(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic put(input logic [31:0] word);
        prog[pc_w] = word;
        pc_w++;
    endtask

    task automatic store_reg(input logic [4:0] r);
        put(i_ins(6'h2b, r, 5'd0, st_off));   // Each store goes to a fresh word
        st_off = st_off + 16'd4;
    endtask

    // Instruction-level model of the ISA subset without delay slots
    function automatic logic [31:0] ref_step(
        input  logic [31:0] pc,
        output logic        st_en,
        output logic [31:0] st_addr,
        output logic [31:0] st_data
    );
        logic [31:0] iw;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] ea;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [4:0]  dst;
        logic        wr;
        iw      = prog[pc[9:2]];
        a       = ref_regs[iw[25:21]];
        b       = ref_regs[iw[20:16]];
        se      = {{16{iw[15]}}, iw[15:0]};
        ze      = {16'h0000, iw[15:0]};
        ea      = a + se;
        nxt     = pc + `CPU_PC_STEP;
        res     = 32'h0;
        dst     = iw[20:16];
        wr      = 1'b1;
        st_en   = 1'b0;
        st_addr = 32'h0;
        st_data = 32'h0;
        case (iw[31:26])
            6'h00: begin
                dst = iw[15:11];
                case (iw[5:0])
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b: res = (a < b) ? 32'd1 : 32'd0;
                    6'h08: begin
                        wr  = 1'b0;
                        nxt = a;
                    end
                    default: wr = 1'b0;   // Shifts and other unsupported codes do nothing
                endcase
            end
            6'h02: begin
                wr  = 1'b0;
                nxt = {nxt[31:28], iw[25:0], 2'b00};
            end
            6'h03: begin
                dst = 5'(`CPU_LINK_REG);
                res = nxt;
                nxt = {nxt[31:28], iw[25:0], 2'b00};
            end
            6'h04: begin
                wr = 1'b0;
                if (a == b) begin
                    nxt = nxt + {se[29:0], 2'b00};
                end
            end
            6'h05: begin
                wr = 1'b0;
                if (a != b) begin
                    nxt = nxt + {se[29:0], 2'b00};
                end
            end
            6'h09: res = a + se;
            6'h0a: res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            6'h0b: res = (a < se) ? 32'd1 : 32'd0;
            6'h0c: res = a & ze;
            6'h0d: res = a | ze;
            6'h0e: res = a ^ ze;
            6'h0f: res = {iw[15:0], 16'h0000};
            6'h23: res = ref_mem[ea[9:2]];
            6'h2b: begin
                wr              = 1'b0;
                st_en           = 1'b1;
                st_addr         = {ea[31:2], 2'b00};
                st_data         = b;
                ref_mem[ea[9:2]] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            ref_regs[dst] = res;
        end
        return nxt;
    endfunction

    task automatic wait_for_store();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (dmem.write !== 1'b1) begin
            cycles++;
            if (cycles > 200) begin
                stop_with_failure("timeout: the DUT issued no expected store within 200 cycles");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    initial begin : main
        logic [31:0] a_val;
        logic [31:0] b_val;
        logic [15:0] imm;
        logic [31:0] model_pc;
        logic [31:0] st_addr;
        logic [31:0] st_data;
        logic        st_en;
        int unsigned seed_ret;
        int          steps;
        int          n_model;
        int          cycles;
        int          t;
        rst      = 1'b1;
        seed_ret = $urandom(32'h6510_99e7);
        for (int i = 0; i < 256; i++) begin
            data_mem[i] = $urandom;
            ref_mem[i]  = data_mem[i];
            prog[i]     = 32'h0;
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'h0;
        end
        pc_w   = 0;
        st_off = 16'h0;
        a_val  = $urandom;
        b_val  = $urandom;
        put(i_ins(6'h0f, 5'd1, 5'd0, a_val[31:16]));
        put(i_ins(6'h0d, 5'd1, 5'd1, a_val[15:0]));
        put(i_ins(6'h0f, 5'd2, 5'd0, b_val[31:16]));
        put(i_ins(6'h0d, 5'd2, 5'd2, b_val[15:0]));
        store_reg(5'd1);
        store_reg(5'd2);
        foreach (prog[k]) begin
            if (k < 8) begin
                put(r_ins(k == 0 ? 6'h21 : k == 1 ? 6'h23 : k == 2 ? 6'h24 : k == 3 ? 6'h25 :
                          k == 4 ? 6'h26 : k == 5 ? 6'h27 : k == 6 ? 6'h2a : 6'h2b,
                          5'd3, 5'd1, 5'd2));
                store_reg(5'd3);
            end
        end
        put(r_ins(6'h2a, 5'd3, 5'd2, 5'd1));
        store_reg(5'd3);
        put(r_ins(6'h2b, 5'd3, 5'd2, 5'd1));
        store_reg(5'd3);
        for (int k = 0; k < 2; k++) begin
            imm = (k == 0) ? (16'($urandom) & 16'h7fff) : (16'($urandom) | 16'h8000);
            for (int op = 6'h09; op <= 6'h0f; op++) begin
                put(i_ins(6'(op), 5'd3, 5'd1, imm));
                store_reg(5'd3);
            end
        end
        put(r_ins(6'h21, 5'd0, 5'd1, 5'd2));   // Write to r0 is lost
        store_reg(5'd0);
        put(32'h0);
        put(32'hfc00_0000);
        put(r_ins(6'h00, 5'd3, 5'd1, 5'd2));   // Unsupported shift leaves r3 alone
        store_reg(5'd3);
        put(i_ins(6'h04, 5'd1, 5'd1, 16'd1));
        store_reg(5'd1);
        put(i_ins(6'h04, 5'd2, 5'd1, 16'd1));
        store_reg(5'd1);
        put(i_ins(6'h05, 5'd2, 5'd1, 16'd1));
        store_reg(5'd2);
        put(i_ins(6'h05, 5'd2, 5'd2, 16'd1));
        store_reg(5'd2);
        put({6'h02, 26'(pc_w + 2)});
        store_reg(5'd1);
        put({6'h03, 26'(pc_w + 2)});
        store_reg(5'd1);
        store_reg(5'd31);
        t = pc_w + 3;
        put(i_ins(6'h0d, 5'd4, 5'd0, 16'(t * 4)));
        put(r_ins(6'h08, 5'd0, 5'd4, 5'd0));
        store_reg(5'd1);
        store_reg(5'd4);
        for (int k = 0; k < 4; k++) begin
            put(i_ins(6'h23, 5'd5, 5'd0, 16'h0200 + 16'(($urandom % 128) * 4)));
            store_reg(5'd5);
        end
        put(i_ins(6'h0d, 5'd6, 5'd0, 16'h0200));
        put(i_ins(6'h23, 5'd5, 5'd6, 16'(($urandom % 128) * 4)));
        store_reg(5'd5);
        put(i_ins(6'h23, 5'd0, 5'd0, 16'h0200 + 16'(($urandom % 128) * 4)));
        store_reg(5'd0);
        loop_pc = 32'(pc_w * 4);
        put(i_ins(6'h04, 5'd0, 5'd0, 16'hffff));   // Branch to itself

        fork
            begin
                repeat (16) @(posedge clk);
                #5 rst = 1'b0;
            end
            begin
                @(posedge clk);
                repeat (16) begin
                    @(negedge clk);
                    check_idle();   // Last pass falls in the first cycle after reset
                end
            end
        join

        model_pc = `CPU_RESET_PC;
        n_model  = 0;
        steps    = 0;
        while (model_pc != loop_pc && steps < 1000) begin
            model_pc = ref_step(model_pc, st_en, st_addr, st_data);
            steps++;
            if (st_en) begin
                wait_for_store();
                compare("dmem.addr", dmem.addr, st_addr);
                compare("dmem.wdata", dmem.wdata, st_data);
                n_model++;
            end
        end
        if (model_pc != loop_pc) begin
            stop_with_failure("the reference model never reached the final loop");
        end else begin
            cycles = 0;
            while (imem.pc !== loop_pc) begin
                cycles++;
                if (cycles > 200) begin
                    stop_with_failure("timeout: the DUT never reached the final loop");
                end else begin
                    @(negedge clk);
                end
            end
            repeat (20) @(negedge clk);   // A few turns of the loop where no store may appear
            compare("store count", 32'(n_writes), 32'(n_model));
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/cpu_fsm.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/exec_stage.sv
logic/mem_wb_stage.sv
logic/simple_cpu.sv
sim/tb_simple_cpu.sv
